// File: testbench/mips_golden.txt
# I word | D byte_addr word | W test reg value | S test byte_addr value
# Hex words, decimal test and register numbers, all in program order
D 00000040 12345678
D 00000044 fffffff0
I 2401fffb
I 34028001
I 3023ff0f
I 2824fffc
I 0022282a
I 00413023
I 00c63821
I 00e34025
I 01074824
I 8c0a0040
I 01495821
I 8c0c0044
I ac0c0048
I ac0b004c
I 8c0d004c
I 8c0e0048
I 240f0003
I 15e40002
I 24100001
I 24110bad
I 8c120040
I 124a0002
I 24130002
I 24140bad
I 11e40001
I 24150004
I 24160005
I 24000077
I 0000b821
I ac000050
I 1000ffff
I 00000000
W 1 1 fffffffb
W 1 2 00008001
W 1 3 0000ff0b
W 1 4 00000001
W 1 5 00000001
W 1 6 00008006
W 2 7 0001000c
W 2 8 0001ff0f
W 2 9 0001000c
W 3 10 12345678
W 3 11 12355684
W 3 12 fffffff0
S 3 00000048 fffffff0
S 4 0000004c 12355684
W 4 13 12355684
W 4 14 fffffff0
W 5 15 00000003
W 5 16 00000001
W 5 18 12345678
W 5 19 00000002
W 5 21 00000004
W 5 22 00000005
W 6 23 00000000
S 6 00000050 00000000

// File: mips_core.f
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
testbench/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f mips_core.f --top-module tb_mips_core
out=$(./obj_dir/Vtb_mips_core)
echo "$out"
if echo "$out" | grep -qF "** PASS **"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    logic            clock = 1'b0;
    logic            rst_n;
    mips_pkg::word_t imem_addr, imem_data;
    mips_pkg::word_t dmem_addr, dmem_write_data, dmem_read_data;
    logic            dmem_read, dmem_write, wb_write;
    mips_pkg::reg_addr_t wb_reg;
    mips_pkg::word_t wb_data;

    mips_pkg::word_t imem [0:63];                   // Word indexed models
    mips_pkg::word_t dmem [0:63];
    int w_test[$], w_reg[$], s_test[$];             // Expected events, program order
    mips_pkg::word_t w_val[$], s_addr[$], s_val[$];
    int left_per_test [0:7];                        // Events still due per test
    int err_per_test [0:7];
    int n_instr, wi, si, stray, strobe_errs, passed, failed;
    logic loaded = 1'b0;

    always #2 clock = ~clock;                       // 4 ns period

    assign imem_data      = imem[imem_addr[7:2]];   // Same-cycle reads
    assign dmem_read_data = dmem_read ? dmem[dmem_addr[7:2]]
                                      : 32'hdead_beef;   // Garbage unless read strobed

    always @(posedge clock) begin
        if (dmem_write) dmem[dmem_addr[7:2]] <= dmem_write_data;
    end

    mips_core #(.RESET_PC(32'h0)) i_dut (
        .clock, .rst_n, .imem_addr, .imem_data,
        .dmem_addr, .dmem_write_data, .dmem_read, .dmem_write, .dmem_read_data,
        .wb_write, .wb_reg, .wb_data
    );

    task automatic load_golden();
        int fd, code, t, r;
        string tag, line;
        logic [31:0] a, v;
        fd = $fopen("testbench/mips_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file testbench/mips_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(line, fd);            // Skip comment text
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h", v);
                imem[n_instr] = v;
                n_instr++;
            end else if (tag == "D") begin
                code = $fscanf(fd, "%h %h", a, v);
                dmem[a[7:2]] = v;
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %d %h", t, r, v);
                w_test.push_back(t);
                w_reg.push_back(r);
                w_val.push_back(v);
                left_per_test[t]++;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%d %h %h", t, a, v);
                s_test.push_back(t);
                s_addr.push_back(a);
                s_val.push_back(v);
                left_per_test[t]++;
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    task automatic check_word(string name, int t, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            err_per_test[t]++;
        end
    endtask

    task automatic retire_event(int t);
        left_per_test[t]--;
        if (left_per_test[t] == 0) begin
            if (err_per_test[t] == 0) passed++;
            else failed++;
            $display("test %0d finished, %0d errors", t, err_per_test[t]);
        end
    endtask

    // Outputs sampled mid-cycle where they are settled
    always @(negedge clock) begin
        if (rst_n && loaded) begin
            if (dmem_read && dmem_write) begin
                $display("Data read and write strobes both high at %0t", $time);
                strobe_errs++;
            end
            if (wb_write) begin
                if (wi >= w_reg.size()) begin
                    $display("Unexpected writeback to r%0d at %0t", wb_reg, $time);
                    stray++;
                end else begin
                    check_word("wb_reg", w_test[wi], w_reg[wi], {27'd0, wb_reg});
                    check_word("wb_data", w_test[wi], w_val[wi], wb_data);
                    retire_event(w_test[wi]);
                    wi++;
                end
            end
            if (dmem_write) begin
                if (si >= s_addr.size()) begin
                    $display("Unexpected store to %h at %0t", dmem_addr, $time);
                    stray++;
                end else begin
                    check_word("dmem_addr", s_test[si], s_addr[si], dmem_addr);
                    check_word("dmem_write_data", s_test[si], s_val[si], dmem_write_data);
                    retire_event(s_test[si]);
                    si++;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;                           // No-op
            dmem[i] = '0;
        end
        load_golden();
        if (!loaded) begin
            $display("** FAIL **");
            $finish;
        end
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        wait (wi == w_reg.size() && si == s_addr.size());
        repeat (12) @(posedge clock);               // Room for stray events
        $display("tests passed %0d failed %0d, stray events %0d, strobe errors %0d",
                 passed, failed, stray, strobe_errs);
        if (failed == 0 && stray == 0 && strobe_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded && rst_n);
        repeat (n_instr * 3 + 50) @(posedge clock);
        $display("Timeout, %0d writebacks and %0d stores never arrived",
                 w_reg.size() - wi, s_addr.size() - si);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic                clock,
    input  logic                rst_n,
    output mips_pkg::word_t     imem_addr,
    input  mips_pkg::word_t     imem_data,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_write_data,
    output logic                dmem_read,
    output logic                dmem_write,
    input  mips_pkg::word_t     dmem_read_data,
    output logic                wb_write,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);

    logic                stall;                     // Hold fetch and decode
    logic                branch_taken;
    mips_pkg::word_t     branch_target;
    mips_pkg::word_t     id_instruction, id_pc_plus4;
    mips_pkg::reg_addr_t id_rs, id_rt;
    mips_pkg::word_t     id_rs_data, id_rt_data;    // Register file read data
    logic                uses_rs, uses_rt, is_branch;
    mips_pkg::fwd_sel_t  id_fwd_rs, id_fwd_rt, ex_fwd_rs, ex_fwd_rt;
    mips_pkg::alu_op_t   ex_alu_op;
    mips_pkg::word_t     ex_a, ex_b, ex_imm;
    logic                ex_use_imm;
    mips_pkg::reg_addr_t ex_rs, ex_rt, ex_dest;
    logic                ex_reg_write, ex_mem_read, ex_mem_write;
    mips_pkg::word_t     mem_alu_result, mem_store_data;
    mips_pkg::reg_addr_t mem_dest;
    logic                mem_reg_write, mem_mem_read, mem_mem_write;

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
        .clock, .rst_n, .stall, .branch_taken, .branch_target,
        .imem_addr, .imem_data,
        .id_instruction, .id_pc_plus4
    );

    register_file i_regs (
        .clock, .rst_n,
        .rs(id_rs), .rt(id_rt), .rs_data(id_rs_data), .rt_data(id_rt_data),
        .wb_write, .wb_reg, .wb_data                // Write port from writeback
    );

    decode_stage i_decode (
        .clock, .rst_n, .stall,
        .instruction(id_instruction), .pc_plus4(id_pc_plus4),
        .rs_data(id_rs_data), .rt_data(id_rt_data),
        .fwd_rs(id_fwd_rs), .fwd_rt(id_fwd_rt),
        .mem_alu_result, .wb_data,
        .rs(id_rs), .rt(id_rt), .uses_rs, .uses_rt, .is_branch,
        .branch_taken, .branch_target,
        .ex_alu_op, .ex_a, .ex_b, .ex_imm, .ex_use_imm,
        .ex_rs, .ex_rt, .ex_dest, .ex_reg_write, .ex_mem_read, .ex_mem_write
    );

    hazard_unit i_hazard (
        .id_rs, .id_rt, .uses_rs, .uses_rt, .is_branch,
        .ex_rs, .ex_rt, .ex_dest, .mem_dest, .wb_dest(wb_reg),
        .ex_reg_write, .ex_mem_read, .mem_reg_write, .mem_mem_read, .wb_write,
        .stall, .id_fwd_rs, .id_fwd_rt, .ex_fwd_rs, .ex_fwd_rt
    );

    execute_stage i_execute (
        .clock, .rst_n,
        .ex_alu_op, .ex_a, .ex_b, .ex_imm, .ex_use_imm,
        .ex_rs, .ex_rt, .ex_dest, .ex_reg_write, .ex_mem_read, .ex_mem_write,
        .fwd_rs(ex_fwd_rs), .fwd_rt(ex_fwd_rt),
        .mem_alu_result, .wb_data,                  // Feedback into own operand muxes
        .mem_alu_result_q(mem_alu_result), .mem_store_data, .mem_dest,
        .mem_reg_write, .mem_mem_read, .mem_mem_write
    );

    memory_stage i_memory (
        .clock, .rst_n,
        .alu_result(mem_alu_result), .store_data(mem_store_data), .dest(mem_dest),
        .reg_write(mem_reg_write), .mem_read(mem_mem_read), .mem_write(mem_mem_write),
        .dmem_addr, .dmem_write_data, .dmem_read, .dmem_write, .dmem_read_data,
        .wb_write, .wb_reg, .wb_data
    );

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     store_data,
    input  mips_pkg::reg_addr_t dest,
    input  logic                reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_write_data,
    output logic                dmem_read,
    output logic                dmem_write,
    input  mips_pkg::word_t     dmem_read_data,
    output logic                wb_write,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);

    assign dmem_addr       = alu_result;            // Byte address from the ALU
    assign dmem_write_data = store_data;
    assign dmem_read       = mem_read;
    assign dmem_write      = mem_write;             // One-cycle strobe

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_write <= 1'b0;
            wb_reg   <= '0;
        end else begin
            wb_write <= reg_write && dest != '0;    // Register zero writes vanish here
            wb_reg   <= dest;
        end
    end

    always_ff @(posedge clock) begin
        wb_data <= mem_read ? dmem_read_data : alu_result;   // Writeback select
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::alu_op_t   ex_alu_op,
    input  mips_pkg::word_t     ex_a,
    input  mips_pkg::word_t     ex_b,
    input  mips_pkg::word_t     ex_imm,
    input  logic                ex_use_imm,
    input  mips_pkg::reg_addr_t ex_rs,
    input  mips_pkg::reg_addr_t ex_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  mips_pkg::fwd_sel_t  fwd_rs,
    input  mips_pkg::fwd_sel_t  fwd_rt,
    input  mips_pkg::word_t     mem_alu_result,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     mem_alu_result_q,
    output mips_pkg::word_t     mem_store_data,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_reg_write,
    output logic                mem_mem_read,
    output logic                mem_mem_write
);

    mips_pkg::word_t a, rt_val, b, result;

    assign a      = mips_pkg::fwd_pick(fwd_rs, ex_a, mem_alu_result, wb_data);
    assign rt_val = mips_pkg::fwd_pick(fwd_rt, ex_b, mem_alu_result, wb_data);
    assign b      = ex_use_imm ? ex_imm : rt_val;   // rt_val still carries store data

    always_comb begin
        case (ex_alu_op)
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            default:           result = a + b;      // Also load and store address
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_dest      <= '0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_dest      <= ex_dest;
        end
    end

    always_ff @(posedge clock) begin
        mem_alu_result_q <= result;
        mem_store_data   <= rt_val;
    end

    // One instruction is either a load or a store, in execute and in memory
    a_ld_st_excl: assert property (@(posedge clock) disable iff (!rst_n)
        !(mem_mem_read && mem_mem_write) && !(ex_mem_read && ex_mem_write))
        else $error("Load and store set together");

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_addr_t id_rs,
    input  mips_pkg::reg_addr_t id_rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  logic                is_branch,
    input  mips_pkg::reg_addr_t ex_rs,
    input  mips_pkg::reg_addr_t ex_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::reg_addr_t wb_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                mem_reg_write,
    input  logic                mem_mem_read,
    input  logic                wb_write,
    output logic                stall,
    output mips_pkg::fwd_sel_t  id_fwd_rs,
    output mips_pkg::fwd_sel_t  id_fwd_rt,
    output mips_pkg::fwd_sel_t  ex_fwd_rs,
    output mips_pkg::fwd_sel_t  ex_fwd_rt
);

    logic rs_live, rt_live;                         // Decode reads a nonzero register
    logic ex_hit_rs, ex_hit_rt, mem_hit_rs, mem_hit_rt, wb_hit_rs, wb_hit_rt;
    logic exm_hit_rs, exm_hit_rt, exw_hit_rs, exw_hit_rt;

    assign rs_live = uses_rs && id_rs != '0;
    assign rt_live = uses_rt && id_rt != '0;

    assign ex_hit_rs  = rs_live && ex_reg_write && ex_dest == id_rs;
    assign ex_hit_rt  = rt_live && ex_reg_write && ex_dest == id_rt;
    assign mem_hit_rs = rs_live && mem_reg_write && mem_dest == id_rs;
    assign mem_hit_rt = rt_live && mem_reg_write && mem_dest == id_rt;
    assign wb_hit_rs  = rs_live && wb_write && wb_dest == id_rs;
    assign wb_hit_rt  = rt_live && wb_write && wb_dest == id_rt;

    // Load-use, branch on an execute result, branch on a load in memory
    assign stall = ((ex_hit_rs || ex_hit_rt) && (ex_mem_read || is_branch))
                || ((mem_hit_rs || mem_hit_rt) && mem_mem_read && is_branch);

    // A load in memory has no data yet, execute picks it up from writeback
    assign id_fwd_rs = mem_hit_rs ? (mem_mem_read ? mips_pkg::FWD_REG : mips_pkg::FWD_MEM)
                     : wb_hit_rs ? mips_pkg::FWD_WB : mips_pkg::FWD_REG;
    assign id_fwd_rt = mem_hit_rt ? (mem_mem_read ? mips_pkg::FWD_REG : mips_pkg::FWD_MEM)
                     : wb_hit_rt ? mips_pkg::FWD_WB : mips_pkg::FWD_REG;

    assign exm_hit_rs = ex_rs != '0 && mem_reg_write && mem_dest == ex_rs;
    assign exm_hit_rt = ex_rt != '0 && mem_reg_write && mem_dest == ex_rt;
    assign exw_hit_rs = ex_rs != '0 && wb_write && wb_dest == ex_rs;
    assign exw_hit_rt = ex_rt != '0 && wb_write && wb_dest == ex_rt;

    assign ex_fwd_rs = exm_hit_rs ? mips_pkg::FWD_MEM           // Nearest stage wins
                     : exw_hit_rs ? mips_pkg::FWD_WB : mips_pkg::FWD_REG;
    assign ex_fwd_rt = exm_hit_rt ? mips_pkg::FWD_MEM
                     : exw_hit_rt ? mips_pkg::FWD_WB : mips_pkg::FWD_REG;

    always_comb begin
        a_no_zero_fwd: assert ((id_fwd_rs == mips_pkg::FWD_REG || id_rs != '0)
                            && (id_fwd_rt == mips_pkg::FWD_REG || id_rt != '0)
                            && (ex_fwd_rs == mips_pkg::FWD_REG || ex_rs != '0)
                            && (ex_fwd_rt == mips_pkg::FWD_REG || ex_rt != '0))
            else $error("Forward select points at register zero");
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                stall,
    input  mips_pkg::word_t     instruction,
    input  mips_pkg::word_t     pc_plus4,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  mips_pkg::fwd_sel_t  fwd_rs,
    input  mips_pkg::fwd_sel_t  fwd_rt,
    input  mips_pkg::word_t     mem_alu_result,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                uses_rs,
    output logic                uses_rt,
    output logic                is_branch,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    output mips_pkg::alu_op_t   ex_alu_op,
    output mips_pkg::word_t     ex_a,
    output mips_pkg::word_t     ex_b,
    output mips_pkg::word_t     ex_imm,
    output logic                ex_use_imm,
    output mips_pkg::reg_addr_t ex_rs,
    output mips_pkg::reg_addr_t ex_rt,
    output mips_pkg::reg_addr_t ex_dest,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rd;
    mips_pkg::alu_op_t   alu_op;
    mips_pkg::word_t     imm_ext, op_a, op_b;
    logic                use_imm, dest_rd, sign_ext;
    logic                reg_write, mem_read, mem_write;

    assign opcode = instruction[31:26];
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign funct  = instruction[5:0];

    always_comb begin
        alu_op    = mips_pkg::ALU_ADD;              // Defaults give a no-op
        use_imm   = 1'b0;
        dest_rd   = 1'b0;
        sign_ext  = 1'b1;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                dest_rd = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:           reg_write = 1'b0;   // Unknown funct, no write
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (opcode)
                    mips_pkg::OP_SLTI: alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  alu_op = mips_pkg::ALU_OR;
                    default:           alu_op = mips_pkg::ALU_ADD;
                endcase
                sign_ext = !(opcode == mips_pkg::OP_ANDI || opcode == mips_pkg::OP_ORI);
            end
            mips_pkg::OP_LW: begin
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;                   // Store data
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                is_branch = 1'b1;
            end
            default: ;                              // Unknown opcode is a no-op
        endcase
    end

    assign imm_ext = sign_ext ? {{16{instruction[15]}}, instruction[15:0]}
                              : {16'h0000, instruction[15:0]};

    assign op_a = mips_pkg::fwd_pick(fwd_rs, rs_data, mem_alu_result, wb_data);
    assign op_b = mips_pkg::fwd_pick(fwd_rt, rt_data, mem_alu_result, wb_data);

    // beq takes on equal, bne on different
    assign branch_taken  = is_branch && ((opcode == mips_pkg::OP_BEQ) == (op_a == op_b));
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clock) begin
        if (!rst_n || stall) begin
            ex_reg_write <= 1'b0;                   // Bubble
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_rs        <= '0;                     // Zero never matches a forward
            ex_rt        <= '0;
            ex_dest      <= '0;
        end else begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_rs        <= rs;
            ex_rt        <= rt;
            ex_dest      <= dest_rd ? rd : rt;
        end
    end

    always_ff @(posedge clock) begin
        ex_alu_op  <= alu_op;
        ex_a       <= op_a;
        ex_b       <= op_b;
        ex_imm     <= imm_ext;
        ex_use_imm <= use_imm;
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                wb_write,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data
);

    mips_pkg::word_t regs [31:1];                   // No storage behind register zero

    always_ff @(posedge clock) begin
        if (wb_write && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through lets decode see the value retiring this cycle
    assign rs_data = (rs == '0) ? '0 : (wb_write && wb_reg == rs) ? wb_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wb_write && wb_reg == rt) ? wb_data : regs[rt];

    a_zero_reads: assert property (@(posedge clock) disable iff (!rst_n)
        (rs == '0 -> rs_data == '0) && (rt == '0 -> rt_data == '0))
        else $error("Register zero read back nonzero");

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t imem_addr,
    input  mips_pkg::word_t imem_data,
    output mips_pkg::word_t id_instruction,
    output mips_pkg::word_t id_pc_plus4
);

    mips_pkg::word_t pc;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t next_pc;

    assign imem_addr = pc;                          // Same-cycle instruction read
    assign pc_plus4  = pc + mips_pkg::PC_STEP;
    assign next_pc   = branch_taken ? branch_target : pc_plus4;   // Delay slot already in flight

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc             <= RESET_PC;
            id_instruction <= '0;                   // All zero word decodes as a no-op
        end else if (!stall) begin
            pc             <= next_pc;
            id_instruction <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            id_pc_plus4 <= pc_plus4;                // Branch base for decode
        end
    end

    a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("PC lost word alignment: %h", pc);

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;                    // Data or byte address
    typedef logic [4:0]  reg_addr_t;                // Register number
    typedef logic [5:0]  opcode_t;                  // Major opcode field
    typedef logic [5:0]  funct_t;                   // R-type function field
    typedef logic [1:0]  fwd_sel_t;                 // Operand source select

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    localparam fwd_sel_t FWD_REG = 2'd0;            // Value the stage already holds
    localparam fwd_sel_t FWD_MEM = 2'd1;            // ALU result sitting in memory stage
    localparam fwd_sel_t FWD_WB  = 2'd2;            // Data being written back

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam word_t PC_STEP = 32'd4;              // Bytes per instruction

    // Forwarding mux shared by the decode and execute operand paths
    function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t reg_val,
                                       input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage
